// File: include/memBus_settings.svh
`ifndef MEMBUS_SETTINGS_SVH
`define MEMBUS_SETTINGS_SVH

// Address space of the CPU port
`define MEM_ADDR_W 18

// Reserved UART locations
`define MEM_UART_DATA 18'h0BF00
`define MEM_UART_STAT 18'h0BF01

// Receive queue holds 2**3 bytes
`define RX_QUEUE_DEPTH_LOG 3

// Wait lengths in clock cycles
`define SRAM_WAIT 2
`define UART_PULSE 2

`endif

// File: design/memBusPkg.sv
`default_nettype none

`include "memBus_settings.svh"

package memBusPkg;

	typedef logic [15:0] word_t;
	typedef logic [`MEM_ADDR_W-1:0] addr_t;
	typedef logic [`RX_QUEUE_DEPTH_LOG-1:0] qPtr_t;

	typedef enum logic [3:0] {
		Idle,
		RxStrobe,
		RxCapture,
		TxStrobe,
		TxWaitTbre,
		TxWaitTsre,
		RamRead,
		RamWrite,
		QueueRead,
		Ack
	} ctrlState_t;

endpackage

`default_nettype wire

// File: design/busPhyIf.sv
`timescale 1ns/1ns
`default_nettype none

interface busPhyIf;
	import memBusPkg::*;

	// Active-high requests from the controller
	logic ramEn;
	logic ramOe;
	logic ramWe;
	logic uartRd;
	logic uartWr;
	logic busDrive;
	word_t busWord;
	addr_t addr;
	logic capture;

	// Captured bus contents
	word_t capWord;
	logic [7:0] capByte;

	modport ctrl (
		output ramEn, ramOe, ramWe, uartRd, uartWr, busDrive, busWord, addr, capture,
		input capWord, capByte
	);

	modport sramPort (
		input ramEn, ramOe, ramWe, addr, capture,
		output capWord
	);

	modport uartPort (
		input uartRd, uartWr, capture,
		output capByte
	);

endinterface

`default_nettype wire

// File: design/rxQueue.sv
`timescale 1ns/1ns
`default_nettype none

`include "memBus_settings.svh"

module rxQueue (
	input logic clk,
	input logic rst,
	input logic push,
	input logic pop,
	input memBusPkg::word_t pushWord,
	output memBusPkg::word_t headWord,
	output logic empty,
	output logic full
);
	import memBusPkg::*;

	localparam int depth = 1 << `RX_QUEUE_DEPTH_LOG;

	word_t mem [depth];
	qPtr_t front;
	qPtr_t tail;
	logic [`RX_QUEUE_DEPTH_LOG:0] count;
	logic doPush;
	logic doPop;

	assign doPush = push && !full;
	assign doPop = pop && !empty;

	assign empty = count == '0;
	// Count never exceeds depth, so the top bit means full
	assign full = count[`RX_QUEUE_DEPTH_LOG];
	assign headWord = mem[front];

	always_ff @(posedge clk) begin
		if (doPush)
			mem[tail] <= pushWord;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			front <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (doPush)
				tail <= tail + 1'b1;
			if (doPop)
				front <= front + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/sramPort.sv
`timescale 1ns/1ns
`default_nettype none

module sramPort (
	input logic clk,
	input logic rst,
	busPhyIf.sramPort phy,
	output memBusPkg::addr_t ramAddr,
	output logic ramEn,
	output logic ramOe,
	output logic ramWe,
	input memBusPkg::word_t ramIn
);

	// Strobes are active low at the chip
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ramEn <= 1'b1;
			ramOe <= 1'b1;
			ramWe <= 1'b1;
		end else begin
			ramEn <= !phy.ramEn;
			ramOe <= !phy.ramOe;
			ramWe <= !phy.ramWe;
		end
	end

	always_ff @(posedge clk) begin
		ramAddr <= phy.addr;
	end

	// Sample while oe is still low
	always_ff @(posedge clk) begin
		if (phy.capture)
			phy.capWord <= ramIn;
	end

endmodule

`default_nettype wire

// File: design/uartPort.sv
`timescale 1ns/1ns
`default_nettype none

module uartPort (
	input logic clk,
	input logic rst,
	input logic uartDataReady,
	input logic uartTbre,
	input logic uartTsre,
	input logic [7:0] uartIn,
	output logic uartRdn,
	output logic uartWrn,
	output logic rxPending,
	output logic txEmpty,
	output logic shiftEmpty,
	busPhyIf.uartPort phy
);

	// Two flop synchronizers for data_ready, tbre, tsre
	logic [2:0] syncA;
	logic [2:0] syncB;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			syncA <= '0;
			syncB <= '0;
			uartRdn <= 1'b1;
			uartWrn <= 1'b1;
		end else begin
			syncA <= {uartDataReady, uartTbre, uartTsre};
			syncB <= syncA;
			uartRdn <= !phy.uartRd;
			uartWrn <= !phy.uartWr;
		end
	end

	assign rxPending = syncB[2];
	assign txEmpty = syncB[1];
	assign shiftEmpty = syncB[0];

	// Received byte, low half of the bus
	always_ff @(posedge clk) begin
		if (phy.capture)
			phy.capByte <= uartIn;
	end

endmodule

`default_nettype wire

// File: design/memBusCtrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "memBus_settings.svh"

module memBusCtrl (
	input logic clk,
	input logic rst,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input memBusPkg::addr_t wbAdr,
	input memBusPkg::word_t wbDatW,
	output memBusPkg::word_t wbDatR,
	output logic wbAck,
	input logic rxPending,
	input logic txEmpty,
	input logic shiftEmpty,
	output logic qPush,
	output logic qPop,
	output memBusPkg::word_t qPushWord,
	input logic qEmpty,
	input logic qFull,
	input memBusPkg::word_t qHead,
	busPhyIf.ctrl phy
);
	import memBusPkg::*;

	localparam logic [3:0] sramLast = 4'(`SRAM_WAIT - 1);
	localparam logic [3:0] pulseLast = 4'(`UART_PULSE - 1);
	// Lag of the wrn register plus the synchronizer depth in uartPort
	localparam logic [3:0] syncSettle = 4'd3;

	ctrlState_t state;
	logic [3:0] cnt;
	logic [1:0] rxHold;
	logic srcRam;
	logic wrRam;
	logic isStat;
	word_t datR;

	logic wbReq;
	logic uartSel;
	logic statSel;

	assign wbReq = wbCyc && wbStb;
	assign uartSel = wbAdr == `MEM_UART_DATA;
	assign statSel = wbAdr == `MEM_UART_STAT;

	//////////////////////////////
	// Sequencing
	//////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= Idle;
			cnt <= '0;
			rxHold <= '0;
			qPush <= 1'b0;
			srcRam <= 1'b0;
			wrRam <= 1'b0;
			isStat <= 1'b0;
		end else begin
			qPush <= 1'b0;
			cnt <= cnt + 4'd1;
			if (rxHold != 2'd0)
				rxHold <= rxHold - 2'd1;
			case (state)
				Idle: begin
					cnt <= '0;
					srcRam <= 1'b0;
					wrRam <= 1'b0;
					// Reception first, as long as the queue has room
					if (rxPending && !qFull && rxHold == 2'd0) begin
						state <= RxStrobe;
					end else if (wbReq) begin
						if (uartSel && wbWe) begin
							state <= TxStrobe;
						end else if (uartSel || statSel) begin
							state <= QueueRead;
							isStat <= statSel;
						end else if (wbWe) begin
							state <= RamWrite;
							wrRam <= 1'b1;
						end else begin
							state <= RamRead;
							srcRam <= 1'b1;
						end
					end
				end
				RxStrobe: begin
					if (cnt == pulseLast) begin
						state <= RxCapture;
						cnt <= '0;
					end
				end
				RxCapture: begin
					state <= Idle;
					qPush <= 1'b1;
					// Stale data_ready still in the synchronizer
					rxHold <= 2'd3;
				end
				TxStrobe: begin
					if (cnt == pulseLast) begin
						state <= TxWaitTbre;
						cnt <= '0;
					end
				end
				TxWaitTbre: begin
					// tbre is only trusted once the synchronizer has caught up
					if (cnt == syncSettle) begin
						cnt <= cnt;
						if (txEmpty)
							state <= TxWaitTsre;
					end
				end
				TxWaitTsre: begin
					if (shiftEmpty)
						state <= Ack;
				end
				RamRead, RamWrite: begin
					if (cnt == sramLast)
						state <= Ack;
				end
				QueueRead: state <= Ack;
				Ack: state <= Idle;
				default: state <= Idle;
			endcase
		end
	end

	// Status word or queue head
	always_ff @(posedge clk) begin
		if (state == QueueRead) begin
			if (isStat)
				datR <= {14'd0, !qEmpty, txEmpty};
			else if (qEmpty)
				datR <= '0;
			else
				datR <= qHead;
		end
	end

	//////////////////////////////
	// Outputs
	//////////////////////////////

	assign wbAck = state == Ack;
	assign wbDatR = srcRam ? phy.capWord : datR;

	assign qPop = state == QueueRead && !isStat && !qEmpty;
	assign qPushWord = {8'h00, phy.capByte};

	assign phy.ramEn = state == RamRead || state == RamWrite;
	assign phy.ramOe = state == RamRead;
	// we rises one cycle before the data leaves the bus
	assign phy.ramWe = state == RamWrite && cnt != sramLast;
	assign phy.uartRd = state == RxStrobe;
	assign phy.uartWr = state == TxStrobe;
	assign phy.busDrive = state == RamWrite || (state == Ack && wrRam) ||
		state == TxStrobe || state == TxWaitTbre;
	assign phy.busWord = wbDatW;
	assign phy.addr = wbAdr;
	assign phy.capture = state == RxCapture || (state == RamRead && cnt == sramLast);

endmodule

`default_nettype wire

// File: design/memBusTop.sv
`timescale 1ns/1ns
`default_nettype none

module memBusTop (
	input logic clk,
	input logic rst,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input memBusPkg::addr_t wbAdr,
	input memBusPkg::word_t wbDatW,
	output memBusPkg::word_t wbDatR,
	output logic wbAck,
	output memBusPkg::addr_t ramAddr,
	output logic ramEn,
	output logic ramOe,
	output logic ramWe,
	inout wire memBusPkg::word_t ramData,
	input logic uartDataReady,
	input logic uartTbre,
	input logic uartTsre,
	output logic uartRdn,
	output logic uartWrn
);
	import memBusPkg::*;

	busPhyIf phy ();

	logic rxPending;
	logic txEmpty;
	logic shiftEmpty;
	logic qPush;
	logic qPop;
	logic qEmpty;
	logic qFull;
	word_t qHead;
	word_t qPushWord;

	memBusCtrl ctrl0 (
		.clk(clk),
		.rst(rst),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.rxPending(rxPending),
		.txEmpty(txEmpty),
		.shiftEmpty(shiftEmpty),
		.qPush(qPush),
		.qPop(qPop),
		.qPushWord(qPushWord),
		.qEmpty(qEmpty),
		.qFull(qFull),
		.qHead(qHead),
		.phy(phy.ctrl)
	);

	sramPort sram0 (
		.clk(clk),
		.rst(rst),
		.phy(phy.sramPort),
		.ramAddr(ramAddr),
		.ramEn(ramEn),
		.ramOe(ramOe),
		.ramWe(ramWe),
		.ramIn(ramData)
	);

	uartPort uart0 (
		.clk(clk),
		.rst(rst),
		.uartDataReady(uartDataReady),
		.uartTbre(uartTbre),
		.uartTsre(uartTsre),
		.uartIn(ramData[7:0]),
		.uartRdn(uartRdn),
		.uartWrn(uartWrn),
		.rxPending(rxPending),
		.txEmpty(txEmpty),
		.shiftEmpty(shiftEmpty),
		.phy(phy.uartPort)
	);

	rxQueue queue0 (
		.clk(clk),
		.rst(rst),
		.push(qPush),
		.pop(qPop),
		.pushWord(qPushWord),
		.headWord(qHead),
		.empty(qEmpty),
		.full(qFull)
	);

	// Shared data bus, the SRAM and UART chips drive it otherwise
	assign ramData = phy.busDrive ? phy.busWord : 'z;

endmodule

`default_nettype wire

// File: sim/boardModel.sv
`timescale 1ns/1ns
`default_nettype none

`include "memBus_settings.svh"

module boardModel (
	input memBusPkg::addr_t ramAddr,
	input logic ramEn,
	input logic ramOe,
	input logic ramWe,
	inout wire memBusPkg::word_t ramData,
	input logic uartRdn,
	input logic uartWrn,
	output logic uartDataReady,
	output logic uartTbre,
	output logic uartTsre,
	input logic [7:0] hostByte,
	input logic hostPush,
	output int hostPending,
	output int txCount
);
	import memBusPkg::*;

	// Transmitter timing, kept off the clock grid
	localparam int tbreDelay = 330;
	localparam int tsreDelay = 340;

	word_t mem [0:(1 << `MEM_ADDR_W) - 1];
	logic [7:0] hostQ [$];
	logic [7:0] rxByte;
	logic [7:0] txLog [0:255];
	logic wrnSeenLow;

	initial begin
		uartDataReady = 1'b0;
		uartTbre = 1'b1;
		uartTsre = 1'b1;
		hostPending = 0;
		txCount = 0;
		rxByte = 8'h00;
		wrnSeenLow = 1'b0;
	end

	//////////////////////////////
	// Asynchronous SRAM
	//////////////////////////////

	assign ramData = (!ramEn && !ramOe) ? mem[ramAddr] : 'z;

	// Write completes on the rising edge of we
	always @(posedge ramWe) begin
		if (!ramEn)
			mem[ramAddr] = ramData;
	end

	//////////////////////////////
	// UART chip
	//////////////////////////////

	assign ramData[7:0] = uartRdn ? 8'bz : rxByte;

	// Host side of the serial line
	always @(posedge hostPush) begin
		hostQ.push_back(hostByte);
		rxByte = hostQ[0];
		hostPending = hostQ.size();
		uartDataReady = 1'b1;
	end

	always @(posedge uartRdn) begin
		if (hostQ.size() != 0) begin
			void'(hostQ.pop_front());
			if (hostQ.size() != 0)
				rxByte = hostQ[0];
			hostPending = hostQ.size();
			uartDataReady = hostQ.size() != 0;
		end
	end

	always @(negedge uartWrn) begin
		wrnSeenLow = 1'b1;
	end

	// Byte is latched as wrn rises, then both empty flags drop for a while
	always @(posedge uartWrn) begin
		if (wrnSeenLow) begin
			if (txCount < 256)
				txLog[txCount] = ramData[7:0];
			txCount = txCount + 1;
			uartTbre = 1'b0;
			uartTsre = 1'b0;
			uartTbre <= #(tbreDelay) 1'b1;
			uartTsre <= #(tbreDelay + tsreDelay) 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: sim/memBusTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "memBus_settings.svh"

module memBusTb;
	import memBusPkg::*;

	localparam int clkPeriod = 100;
	localparam int sramOps = 64;
	localparam int txBytes = 16;
	localparam int rxBytes = 4;
	localparam int burstBytes = 12;
	localparam int mixOps = 16;
	localparam int queueDepth = 1 << `RX_QUEUE_DEPTH_LOG;
	// Writes, reads and injected bytes of all tests
	localparam int numTxn = 1 + 2 * sramOps + txBytes + 2 * rxBytes + 1 +
		2 * burstBytes + 3 * mixOps;
	localparam int pollLimit = 40;

	logic clk;
	logic rst;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	addr_t wbAdr;
	word_t wbDatW;
	word_t wbDatR;
	logic wbAck;
	addr_t ramAddr;
	logic ramEn;
	logic ramOe;
	logic ramWe;
	wire word_t ramData;
	logic uartDataReady;
	logic uartTbre;
	logic uartTsre;
	logic uartRdn;
	logic uartWrn;
	logic [7:0] hostByte;
	logic hostPush;
	int hostPending;
	int txCount;

	// Reference model
	word_t ramModel [addr_t];
	addr_t usedAddr [$];
	logic [7:0] rxModel [$];
	logic [7:0] txModel [$];

	int errors;
	int checks;
	int testErrors;
	int testsRun;
	int testsFailed;

	memBusTop dut0 (
		.clk(clk),
		.rst(rst),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.ramAddr(ramAddr),
		.ramEn(ramEn),
		.ramOe(ramOe),
		.ramWe(ramWe),
		.ramData(ramData),
		.uartDataReady(uartDataReady),
		.uartTbre(uartTbre),
		.uartTsre(uartTsre),
		.uartRdn(uartRdn),
		.uartWrn(uartWrn)
	);

	boardModel board0 (
		.ramAddr(ramAddr),
		.ramEn(ramEn),
		.ramOe(ramOe),
		.ramWe(ramWe),
		.ramData(ramData),
		.uartRdn(uartRdn),
		.uartWrn(uartWrn),
		.uartDataReady(uartDataReady),
		.uartTbre(uartTbre),
		.uartTsre(uartTsre),
		.hostByte(hostByte),
		.hostPush(hostPush),
		.hostPending(hostPending),
		.txCount(txCount)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(numTxn * 40 * clkPeriod);
		$display("Watchdog: the run did not finish within %0d cycles", numTxn * 40);
		$display("=== FAIL ===");
		$finish;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
			testErrors++;
		end
	endtask

	task automatic reportFailure(input string what);
		$display("Error at %0t ns: %s", $time, what);
		errors++;
		testErrors++;
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (testErrors != 0)
			testsFailed++;
		$display("Test %0d %s: %s, %0d errors", testsRun, name,
			testErrors == 0 ? "ok" : "failed", testErrors);
		testErrors = 0;
	endtask

	// One classic Wishbone cycle held until wbAck
	task automatic busCycle(input logic we, input addr_t adr, input word_t datW,
		output word_t datR);
		@(negedge clk);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = adr;
		wbDatW = datW;
		do
			@(negedge clk);
		while (!wbAck);
		datR = wbDatR;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic writeWord(input addr_t adr, input word_t dat);
		word_t unused;
		busCycle(1'b1, adr, dat, unused);
	endtask

	task automatic readWord(input addr_t adr, output word_t dat);
		busCycle(1'b0, adr, '0, dat);
	endtask

	task automatic injectByte(input logic [7:0] b);
		@(negedge clk);
		hostByte = b;
		hostPush = 1'b1;
		@(negedge clk);
		hostPush = 1'b0;
		rxModel.push_back(b);
	endtask

	// Poll the status word until a received byte is reported
	task automatic waitRxData();
		word_t stat;
		int polls;
		stat = '0;
		polls = 0;
		while (!stat[1] && polls < pollLimit) begin
			readWord(`MEM_UART_STAT, stat);
			polls++;
		end
		if (!stat[1])
			reportFailure("status bit 1 never showed a received byte");
	endtask

	task automatic drainRx();
		word_t got;
		logic [7:0] exp;
		while (rxModel.size() != 0) begin
			exp = rxModel.pop_front();
			waitRxData();
			readWord(`MEM_UART_DATA, got);
			checkValue("wbDatR", got, {8'h00, exp});
		end
	endtask

	function automatic addr_t randomRamAddr();
		addr_t adr;
		adr = addr_t'($urandom);
		// Keep clear of the UART locations
		if (adr == `MEM_UART_DATA || adr == `MEM_UART_STAT)
			adr[`MEM_ADDR_W-1] = 1'b1;
		return adr;
	endfunction

	//////////////////////////////
	// Tests
	//////////////////////////////

	initial begin
		word_t got;
		word_t dat;
		addr_t adr;
		int seed;
		int txBase;

		seed = 32'h232e;
		void'($urandom(seed));
		errors = 0;
		checks = 0;
		testErrors = 0;
		testsRun = 0;
		testsFailed = 0;
		rst = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		hostByte = 8'h00;
		hostPush = 1'b0;
		repeat (3) @(negedge clk);
		rst = 1'b1;

		checkValue("ramEn", ramEn, 1'b1);
		checkValue("ramOe", ramOe, 1'b1);
		checkValue("ramWe", ramWe, 1'b1);
		checkValue("uartRdn", uartRdn, 1'b1);
		checkValue("uartWrn", uartWrn, 1'b1);
		checkValue("wbAck", wbAck, 1'b0);
		readWord(`MEM_UART_STAT, got);
		checkValue("wbDatR status bit 1", got[1], 1'b0);
		checkValue("wbDatR status bit 0", got[0], 1'b1);
		finishTest("reset state");

		// Some writes land on earlier addresses
		for (int i = 0; i < sramOps; i++) begin
			if (usedAddr.size() != 0 && $urandom % 4 == 0) begin
				adr = usedAddr[$urandom % usedAddr.size()];
			end else begin
				adr = randomRamAddr();
				usedAddr.push_back(adr);
			end
			dat = word_t'($urandom);
			writeWord(adr, dat);
			ramModel[adr] = dat;
		end
		// Chip cells behind the ramAddr pins
		for (int i = 0; i < usedAddr.size(); i++)
			checkValue("sram cell", board0.mem[usedAddr[i]], ramModel[usedAddr[i]]);
		for (int i = 0; i < sramOps; i++) begin
			adr = usedAddr[$urandom % usedAddr.size()];
			readWord(adr, got);
			checkValue("wbDatR", got, ramModel[adr]);
		end
		finishTest("sram write and read");

		txBase = txCount;
		for (int i = 0; i < txBytes; i++) begin
			dat = word_t'($urandom);
			writeWord(`MEM_UART_DATA, dat);
			txModel.push_back(dat[7:0]);
		end
		checkValue("txCount", txCount - txBase, txBytes);
		for (int i = 0; i < txModel.size(); i++)
			checkValue("uart tx byte", board0.txLog[txBase + i], txModel[i]);
		finishTest("uart transmit");

		for (int i = 0; i < rxBytes; i++)
			injectByte(8'($urandom));
		drainRx();
		readWord(`MEM_UART_STAT, got);
		checkValue("wbDatR status bit 1", got[1], 1'b0);
		readWord(`MEM_UART_DATA, got);
		checkValue("wbDatR", got, 16'h0000);
		finishTest("uart receive");

		for (int i = 0; i < burstBytes; i++)
			injectByte(8'($urandom));
		wait (hostPending <= burstBytes - queueDepth);
		// With the queue full nothing more may leave the chip
		repeat (20) @(negedge clk);
		checkValue("hostPending", hostPending, burstBytes - queueDepth);
		checkValue("uartDataReady", uartDataReady, 1'b1);
		drainRx();
		finishTest("receive back-pressure");

		usedAddr.delete();
		for (int i = 0; i < mixOps; i++) begin
			adr = randomRamAddr();
			dat = word_t'($urandom);
			writeWord(adr, dat);
			ramModel[adr] = dat;
			usedAddr.push_back(adr);
			if ($urandom % 2 == 0 && rxModel.size() < queueDepth)
				injectByte(8'($urandom));
		end
		for (int i = 0; i < mixOps; i++) begin
			adr = usedAddr[$urandom % usedAddr.size()];
			readWord(adr, got);
			checkValue("wbDatR", got, ramModel[adr]);
		end
		drainRx();
		finishTest("receive during sram traffic");

		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
design/memBusPkg.sv
design/busPhyIf.sv
design/rxQueue.sv
design/sramPort.sv
design/uartPort.sv
design/memBusCtrl.sv
design/memBusTop.sv
sim/boardModel.sv
sim/memBusTb.sv

// File: Bender.yml
package:
  name: memBus

sources:
  - include_dirs:
      - include
    files:
      - design/memBusPkg.sv
      - design/busPhyIf.sv
      - design/rxQueue.sv
      - design/sramPort.sv
      - design/uartPort.sv
      - design/memBusCtrl.sv
      - design/memBusTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/boardModel.sv
      - sim/memBusTb.sv
